//--- src/systolic_defs.svh
`ifndef SYSTOLIC_DEFS_SVH
`define SYSTOLIC_DEFS_SVH

// Number format, bfloat16
`define DATA_W 16       // Whole word
`define EXP_W 8         // Exponent field
`define M_W 7           // Stored mantissa, hidden bit not counted
`define MULT_W 16       // Product of two hidden-bit significands
`define EXP_BIAS 127

// Array geometry
`define ARRAY_N 2       // Edge of the square PE grid

// Frame sizes
// Eight operand words, high byte first
`define PAYLOAD_BYTES 16
`define RESULT_WORDS 4  // C11, C12, C21, C22

// Start cycles from load until the last bottom-row sum has
// passed the deskew line, 3 * ARRAY_N
`define COMPUTE_CYCLES 6

`endif

//--- src/float_pkg.sv
`default_nettype none

`include "systolic_defs.svh"

// Types for the bfloat16 number format
package float_pkg;

    // Sign, exponent, mantissa from MSB down
    typedef logic [`DATA_W-1:0] bf16_t;

    // Biased exponent field
    typedef logic [`EXP_W-1:0] exp_t;

    // Mantissa with the hidden 1 restored
    typedef logic [`M_W:0] sig_t;

endpackage

`default_nettype wire

//--- src/link_pkg.sv
`default_nettype none

// Byte link types and controller FSM encodings
package link_pkg;

    typedef logic [7:0] byte_t; // One link byte

    // Frame markers, used as opcodes on both directions of the link
    typedef enum logic [7:0] {
        MARK_START = 8'hFE,
        MARK_END   = 8'hFF
    } marker_e;

    typedef enum logic [1:0] {
        WAIT_START, // Hunting for FE
        PAYLOAD,    // Collecting operand bytes
        BUSY        // Multiply running or result going out
    } rx_state_e;

    // Each state names the byte currently on tx_byte_o
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEAD,
        TX_DATA,
        TX_TAIL
    } tx_state_e;

endpackage

`default_nettype wire

//--- src/bf16_mul.sv
`default_nettype none

`include "systolic_defs.svh"

module bf16_mul (
    input  wire float_pkg::bf16_t a_i,
    input  wire float_pkg::bf16_t b_i,
    output float_pkg::bf16_t      product_o
);
    import float_pkg::*;

    localparam logic [`EXP_W+1:0] BIAS = `EXP_BIAS;
    localparam logic [`EXP_W+1:0] EXP_MAX = (1 << `EXP_W) - 2; // 254

    exp_t exp_a, exp_b;
    sig_t sig_a, sig_b;
    logic [`MULT_W-1:0] prod;
    logic [`EXP_W+1:0] exp_sum;  // Two spare bits, wraps high when negative
    logic [`M_W-1:0] man;
    logic sign;
    logic zero_in;
    logic out_of_range;

    assign exp_a = a_i[`DATA_W-2:`M_W];
    assign exp_b = b_i[`DATA_W-2:`M_W];
    assign sig_a = {1'b1, a_i[`M_W-1:0]};
    assign sig_b = {1'b1, b_i[`M_W-1:0]};
    assign sign = a_i[`DATA_W-1] ^ b_i[`DATA_W-1];

    assign prod = sig_a * sig_b; // Lies in [1,4)

    // Top bit set means product >= 2, so drop one more bit and bump the exponent
    assign man = prod[`MULT_W-1] ? prod[`MULT_W-2 -: `M_W] : prod[`MULT_W-3 -: `M_W];
    assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b}
                   + {{(`EXP_W+1){1'b0}}, prod[`MULT_W-1]} - BIAS;

    assign zero_in = (exp_a == '0) || (exp_b == '0);
    // A negative sum wraps above EXP_MAX as well
    assign out_of_range = (exp_sum == '0) || (exp_sum > EXP_MAX);

    always_comb begin
        if (zero_in) begin
            product_o = '0;
        end else if (out_of_range) begin
            product_o = {sign, {`EXP_W{1'b1}}, {`M_W{1'b0}}}; // Saturate, both ways
        end else begin
            product_o = {sign, exp_sum[`EXP_W-1:0], man}; // Truncated, no rounding
        end
    end

endmodule

`default_nettype wire

//--- src/bf16_add.sv
`default_nettype none

`include "systolic_defs.svh"

module bf16_add (
    input  wire float_pkg::bf16_t a_i,
    input  wire float_pkg::bf16_t b_i,
    output float_pkg::bf16_t      sum_o
);
    import float_pkg::*;

    bf16_t big;
    bf16_t lesser;
    exp_t exp_big;
    exp_t exp_small;
    exp_t exp_diff;
    exp_t exp_res;
    sig_t sig_big;
    sig_t sig_small;
    logic [`M_W+1:0] sig_sum; // One carry bit over the significand
    logic [`M_W-1:0] man_res;
    logic exception;
    logic like_sign;

    // Magnitude compare works on exponent and mantissa as one field
    assign {big, lesser} = (a_i[`DATA_W-2:0] < b_i[`DATA_W-2:0]) ? {b_i, a_i} : {a_i, b_i};

    assign exp_big = big[`DATA_W-2:`M_W];
    assign exp_small = lesser[`DATA_W-2:`M_W];
    assign sig_big = {1'b1, big[`M_W-1:0]};
    assign sig_small = {1'b1, lesser[`M_W-1:0]};

    assign exp_diff = exp_big - exp_small;
    assign sig_sum = {1'b0, sig_big} + {1'b0, sig_small >> exp_diff}; // Align then add

    // Carry out renormalizes by one place and drops the low bit
    assign man_res = sig_sum[`M_W+1] ? sig_sum[`M_W:1] : sig_sum[`M_W-1:0];
    assign exp_res = exp_big + {{(`EXP_W-1){1'b0}}, sig_sum[`M_W+1]};

    assign exception = (&exp_big) | (&exp_small);
    assign like_sign = (a_i[`DATA_W-1] == b_i[`DATA_W-1]);

    always_comb begin
        if (a_i[`DATA_W-2:`M_W] == '0) begin
            sum_o = b_i;                          // Zero passes the other side through
        end else if (b_i[`DATA_W-2:`M_W] == '0) begin
            sum_o = a_i;
        end else if (exception || !like_sign) begin
            sum_o = '0;                           // Inf/NaN and subtraction not supported
        end else begin
            sum_o = {big[`DATA_W-1], exp_res, man_res};
        end
    end

endmodule

`default_nettype wire

//--- src/processing_element.sv
`default_nettype none

module processing_element (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   weight_en_i,   // Load the stationary weight
    input  wire                   compute_i,     // Advance one wavefront step
    input  wire float_pkg::bf16_t weight_i,
    input  wire float_pkg::bf16_t act_west_i,
    input  wire float_pkg::bf16_t psum_north_i,
    output float_pkg::bf16_t      act_east_o,
    output float_pkg::bf16_t      psum_south_o
);
    import float_pkg::*;

    bf16_t weight_q;
    bf16_t product;
    bf16_t psum_next;

    bf16_mul mul_inst (
        .a_i      (act_west_i),
        .b_i      (weight_q),
        .product_o(product)
    );

    // Incoming partial sum first, product second
    bf16_add add_inst (
        .a_i  (psum_north_i),
        .b_i  (product),
        .sum_o(psum_next)
    );

    always_ff @(posedge clk) begin
        if (weight_en_i) weight_q <= weight_i; // Held for the whole run
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            act_east_o <= '0;
            psum_south_o <= '0;
        end else if (compute_i) begin
            act_east_o <= act_west_i;   // Activation marches east
            psum_south_o <= psum_next;  // Sum marches south
        end
    end

endmodule

`default_nettype wire

//--- src/systolic_core.sv
`default_nettype none

`include "systolic_defs.svh"

module systolic_core (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   load_i,
    input  wire                   start_i,
    input  wire float_pkg::bf16_t a_words_i [0:`ARRAY_N*`ARRAY_N-1], // Row-major A
    input  wire float_pkg::bf16_t b_words_i [0:`ARRAY_N*`ARRAY_N-1], // Row-major B
    output logic                  done_o,
    output float_pkg::bf16_t      result_words_o [0:`RESULT_WORDS-1]
);
    import float_pkg::*;

    localparam int N = `ARRAY_N;
    localparam int SR_LEN = 2 * N - 1;  // Column of A plus the row skew
    localparam int CNT_W = $clog2(`COMPUTE_CYCLES);

    bf16_t act_sr [N][SR_LEN];    // Row feeders, element 0 enters the grid
    bf16_t act_h [N][N];          // West input of each cell
    bf16_t psum_v [N+1][N];       // North input of each cell, row N is the bottom edge
    bf16_t deskew [SR_LEN][N];    // Bottom-row sums, newest at 0
    logic [CNT_W-1:0] cycle_cnt;
    logic last_cycle;

    assign last_cycle = (cycle_cnt == CNT_W'(`COMPUTE_CYCLES - 1));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cycle_cnt <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;  // Single-cycle pulse
            if (load_i) begin
                cycle_cnt <= '0;
            end else if (start_i) begin
                if (last_cycle) begin
                    cycle_cnt <= '0;
                    done_o <= 1'b1;
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < SR_LEN; k++) act_sr[r][k] <= '0;
                // Row r carries column r of A, delayed r slots
                for (int i = 0; i < N; i++) act_sr[r][i+r] <= a_words_i[i*N+r];
            end
        end else if (start_i) begin
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < SR_LEN - 1; k++) act_sr[r][k] <= act_sr[r][k+1];
                act_sr[r][SR_LEN-1] <= '0; // Zeros trail the operands
            end
            for (int c = 0; c < N; c++) begin
                deskew[0][c] <= psum_v[N][c];
                for (int k = 1; k < SR_LEN; k++) deskew[k][c] <= deskew[k-1][c];
            end
            if (last_cycle) begin
                // C[i][j] left the grid i+j cycles after C[0][0], so it sits i+j taps nearer
                for (int i = 0; i < N; i++) begin
                    for (int j = 0; j < N; j++) begin
                        result_words_o[i*N+j] <= deskew[SR_LEN-1-i-j][j];
                    end
                end
            end
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_top
        assign psum_v[0][c] = '0; // No partial sum above the top row
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        assign act_h[r][0] = act_sr[r][0];
        for (genvar c = 0; c < N; c++) begin : g_col
            if (c < N - 1) begin : g_inner
                processing_element pe_inst (
                    .clk(clk), .reset(reset),
                    .weight_en_i(load_i), .compute_i(start_i),
                    .weight_i(b_words_i[r*N+c]),        // Cell (r,c) keeps B[r][c]
                    .act_west_i(act_h[r][c]), .psum_north_i(psum_v[r][c]),
                    .act_east_o(act_h[r][c+1]), .psum_south_o(psum_v[r+1][c])
                );
            end else begin : g_edge
                processing_element pe_inst (
                    .clk(clk), .reset(reset),
                    .weight_en_i(load_i), .compute_i(start_i),
                    .weight_i(b_words_i[r*N+c]),
                    .act_west_i(act_h[r][c]), .psum_north_i(psum_v[r][c]),
                    .act_east_o(), .psum_south_o(psum_v[r+1][c]) // East edge drops out
                );
            end
        end
    end

endmodule

`default_nettype wire

//--- src/frame_controller.sv
`default_nettype none

`include "systolic_defs.svh"

module frame_controller (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   rx_valid_i,
    input  wire link_pkg::byte_t  rx_byte_i,
    output logic                  tx_valid_o,
    output link_pkg::byte_t       tx_byte_o,
    output logic                  busy_o,
    output logic                  load_o,
    output logic                  start_o,
    output float_pkg::bf16_t      a_words_o [0:`ARRAY_N*`ARRAY_N-1],
    output float_pkg::bf16_t      b_words_o [0:`ARRAY_N*`ARRAY_N-1],
    input  wire                   done_i,
    input  wire float_pkg::bf16_t result_words_i [0:`RESULT_WORDS-1]
);
    import float_pkg::*;
    import link_pkg::*;

    localparam int MAT_WORDS = `ARRAY_N * `ARRAY_N;
    localparam int BC_W = $clog2(`PAYLOAD_BYTES);
    localparam int WC_W = $clog2(`RESULT_WORDS);

    rx_state_e rx_state;
    tx_state_e tx_state;
    logic [BC_W-1:0] byte_cnt;       // Payload byte index
    bf16_t operand_q [2*MAT_WORDS];  // A words then B words
    logic [WC_W-1:0] word_cnt;       // Next result word to send
    logic half_sel;                  // 0 high byte, 1 low byte
    bf16_t tx_word;
    byte_t data_byte;

    assign busy_o = (rx_state == BUSY);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rx_state <= WAIT_START;
            byte_cnt <= '0;
            load_o <= 1'b0;
            start_o <= 1'b0;
        end else begin
            load_o <= 1'b0;
            case (rx_state)
                WAIT_START: begin
                    if (rx_valid_i && rx_byte_i == MARK_START) begin // Anything else is junk
                        rx_state <= PAYLOAD;
                        byte_cnt <= '0;
                    end
                end
                PAYLOAD: begin
                    if (rx_valid_i) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == BC_W'(`PAYLOAD_BYTES - 1)) begin
                            rx_state <= BUSY;
                            load_o <= 1'b1;
                        end
                    end
                end
                BUSY: begin
                    // Strobes are dropped here
                    if (load_o) start_o <= 1'b1;
                    else if (done_i) start_o <= 1'b0;
                    if (tx_state == TX_TAIL) rx_state <= WAIT_START; // FF is on the wire now
                end
                default: rx_state <= WAIT_START;
            endcase
        end
    end

    // Operand assembly, high byte first
    always_ff @(posedge clk) begin
        if (rx_state == PAYLOAD && rx_valid_i) begin
            if (byte_cnt[0]) operand_q[byte_cnt[BC_W-1:1]][7:0] <= rx_byte_i;
            else operand_q[byte_cnt[BC_W-1:1]][15:8] <= rx_byte_i;
        end
    end

    always_comb begin
        for (int i = 0; i < MAT_WORDS; i++) begin
            a_words_o[i] = operand_q[i];
            b_words_o[i] = operand_q[MAT_WORDS+i];
        end
    end

    assign tx_word = result_words_i[word_cnt];
    assign data_byte = half_sel ? tx_word[7:0] : tx_word[15:8];

    // Result frame, one byte per cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tx_state <= TX_IDLE;
            tx_valid_o <= 1'b0;
            tx_byte_o <= '0;
            word_cnt <= '0;
            half_sel <= 1'b0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (start_o && done_i) begin
                        tx_state <= TX_HEAD;
                        tx_valid_o <= 1'b1;
                        tx_byte_o <= MARK_START;
                        word_cnt <= '0;
                        half_sel <= 1'b0;
                    end
                end
                TX_HEAD: begin
                    tx_state <= TX_DATA;
                    tx_byte_o <= data_byte;
                    {word_cnt, half_sel} <= {word_cnt, half_sel} + 1'b1;
                end
                TX_DATA: begin
                    if (word_cnt == '0 && !half_sel) begin // Counter wrapped, all eight sent
                        tx_state <= TX_TAIL;
                        tx_byte_o <= MARK_END;
                    end else begin
                        tx_byte_o <= data_byte;
                        {word_cnt, half_sel} <= {word_cnt, half_sel} + 1'b1;
                    end
                end
                TX_TAIL: begin
                    tx_state <= TX_IDLE;
                    tx_valid_o <= 1'b0;
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/neural_chip_top.sv
`default_nettype none

`include "systolic_defs.svh"

module neural_chip_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  rx_valid_i,
    input  wire link_pkg::byte_t rx_byte_i,
    output logic                 tx_valid_o,
    output link_pkg::byte_t      tx_byte_o,
    output logic                 busy_o      // Frame in progress, strobes ignored
);
    import float_pkg::*;

    logic load;
    logic start;
    logic done;
    bf16_t a_words [0:`ARRAY_N*`ARRAY_N-1];
    bf16_t b_words [0:`ARRAY_N*`ARRAY_N-1];
    bf16_t result_words [0:`RESULT_WORDS-1];

    frame_controller frame_controller_inst (
        .clk(clk), .reset(reset),
        .rx_valid_i(rx_valid_i), .rx_byte_i(rx_byte_i),
        .tx_valid_o(tx_valid_o), .tx_byte_o(tx_byte_o),
        .busy_o(busy_o),
        .load_o(load), .start_o(start),
        .a_words_o(a_words), .b_words_o(b_words),
        .done_i(done), .result_words_i(result_words)
    );

    systolic_core systolic_core_inst (
        .clk(clk), .reset(reset),
        .load_i(load), .start_i(start),
        .a_words_i(a_words), .b_words_i(b_words),
        .done_o(done), .result_words_o(result_words)
    );

endmodule

`default_nettype wire

//--- testbench/tb_bf16_model.svh
`ifndef TB_BF16_MODEL_SVH
`define TB_BF16_MODEL_SVH

`include "systolic_defs.svh"

// Reference arithmetic for the result frame that truncates like the chip
// Needs float_pkg imported in the including module

// Sign XOR and hidden-bit product with an exponent bump when the product reaches two
function automatic bf16_t mul_truncated(input bf16_t a, input bf16_t b);
    int ea;
    int eb;
    int e;
    int prod;
    logic sign;
    logic [`M_W-1:0] man;
    ea = int'(a[`DATA_W-2:`M_W]);
    eb = int'(b[`DATA_W-2:`M_W]);
    sign = a[`DATA_W-1] ^ b[`DATA_W-1];
    if (ea == 0 || eb == 0) return '0;            // Zero operand
    prod = ((1 << `M_W) + int'(a[`M_W-1:0])) * ((1 << `M_W) + int'(b[`M_W-1:0]));
    e = ea + eb - `EXP_BIAS;
    if (prod >= (1 << (2 * `M_W + 1))) begin      // Product in [2,4)
        e = e + 1;
        man = `M_W'(prod >> (`M_W + 1));
    end else begin
        man = `M_W'(prod >> `M_W);
    end
    if (e < 1 || e > 254) return {sign, {`EXP_W{1'b1}}, {`M_W{1'b0}}};
    return {sign, `EXP_W'(e), man};
endfunction

// Like-signed add where a zero passes the other side and anything else flushes to zero
function automatic bf16_t add_like_signed(input bf16_t a, input bf16_t b);
    bf16_t big;
    bf16_t lesser;
    int e_big;
    int shift;
    int sum;
    if (a[`DATA_W-2:`M_W] == '0) return b;
    if (b[`DATA_W-2:`M_W] == '0) return a;
    if (&a[`DATA_W-2:`M_W] || &b[`DATA_W-2:`M_W]) return '0;
    if (a[`DATA_W-1] != b[`DATA_W-1]) return '0;  // No subtraction
    if (a[`DATA_W-2:0] >= b[`DATA_W-2:0]) begin
        big = a;
        lesser = b;
    end else begin
        big = b;
        lesser = a;
    end
    e_big = int'(big[`DATA_W-2:`M_W]);
    shift = e_big - int'(lesser[`DATA_W-2:`M_W]);
    sum = (1 << `M_W) + int'(big[`M_W-1:0]);
    if (shift <= `M_W) sum = sum + (((1 << `M_W) + int'(lesser[`M_W-1:0])) >> shift);
    if (sum >= (1 << (`M_W + 1))) begin           // Carry renormalizes by one place
        e_big = e_big + 1;
        sum = sum >> 1;
    end
    return {big[`DATA_W-1], `EXP_W'(e_big), `M_W'(sum)};
endfunction

// C[i][j] summed in the order A[i][0]*B[0][j] + A[i][1]*B[1][j]
function automatic bf16_t matmul_entry(input bf16_t a_m [`ARRAY_N*`ARRAY_N],
                                       input bf16_t b_m [`ARRAY_N*`ARRAY_N],
                                       input int i, input int j);
    bf16_t acc;
    acc = '0;
    for (int k = 0; k < `ARRAY_N; k++) begin
        acc = add_like_signed(acc, mul_truncated(a_m[i*`ARRAY_N+k], b_m[k*`ARRAY_N+j]));
    end
    return acc;
endfunction

`endif

//--- testbench/tb_neural_chip.sv
`default_nettype none

`include "systolic_defs.svh"

module tb_neural_chip;
    timeunit 1ns;
    timeprecision 1ps;

    import float_pkg::*;
    import link_pkg::*;

    `include "tb_bf16_model.svh"

    localparam int MAT_WORDS = `ARRAY_N * `ARRAY_N;
    localparam int FRAME_BYTES = 2 * `RESULT_WORDS + 2;  // FE, eight data bytes, FF
    localparam int LATENCY_LIMIT = 20;
    // Six frames of about 45 cycles each plus reset and idle checks leave margin
    localparam int CYCLE_LIMIT = 400;

    logic clk;
    logic reset;
    logic rx_valid;
    byte_t rx_byte;
    logic tx_valid;
    byte_t tx_byte;
    logic busy;

    byte_t tx_q [$];       // Bytes seen on the transmit link
    integer seed;
    int err_count = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    int cycle_cnt = 0;

    neural_chip_top neural_chip_top_inst (
        .clk(clk), .reset(reset),
        .rx_valid_i(rx_valid), .rx_byte_i(rx_byte),
        .tx_valid_o(tx_valid), .tx_byte_o(tx_byte),
        .busy_o(busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Sampled mid-cycle away from the active edge
    always @(negedge clk) begin
        if (tx_valid) tx_q.push_back(tx_byte);
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_word(input string name, input bf16_t expected, input bf16_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // One strobe that stays high only if the next call follows straight away
    task automatic send_byte(input byte_t b);
        @(posedge clk);
        #2;
        rx_valid = 1'b1;
        rx_byte = b;
    endtask

    task automatic release_link();
        @(posedge clk);
        #2;
        rx_valid = 1'b0;
        rx_byte = '0;
    endtask

    task automatic send_frame(input bf16_t a_m [MAT_WORDS], input bf16_t b_m [MAT_WORDS]);
        send_byte(MARK_START);
        for (int i = 0; i < MAT_WORDS; i++) begin
            send_byte(a_m[i][15:8]);  // High byte first
            send_byte(a_m[i][7:0]);
        end
        for (int i = 0; i < MAT_WORDS; i++) begin
            send_byte(b_m[i][15:8]);
            send_byte(b_m[i][7:0]);
        end
        release_link();
    endtask

    task automatic expect_model(input bf16_t a_m [MAT_WORDS], input bf16_t b_m [MAT_WORDS],
                                output bf16_t exp_c [`RESULT_WORDS]);
        for (int i = 0; i < `ARRAY_N; i++) begin
            for (int j = 0; j < `ARRAY_N; j++) exp_c[i*`ARRAY_N+j] = matmul_entry(a_m, b_m, i, j);
        end
    endtask

    // First byte within the latency bound and then the rest of the frame
    task automatic wait_frame(input string name, output logic ok);
        int waited;
        ok = 1'b0;
        waited = 0;
        while (tx_q.size() == 0 && waited < LATENCY_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (tx_q.size() == 0) begin
            $display("%s: no result frame arrived within %0d cycles", name, LATENCY_LIMIT);
            err_count++;
        end else begin
            waited = 0;
            while (tx_q.size() < FRAME_BYTES && waited < FRAME_BYTES) begin
                @(posedge clk);
                waited++;
            end
            if (tx_q.size() != FRAME_BYTES) begin
                $display("%s: result frame held %0d bytes instead of %0d",
                         name, tx_q.size(), FRAME_BYTES);
                err_count++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic check_frame(input string name, input bf16_t exp_c [`RESULT_WORDS]);
        logic ok;
        wait_frame(name, ok);
        if (ok) begin
            compare_byte({name, " head"}, MARK_START, tx_q[0]);
            for (int i = 0; i < `RESULT_WORDS; i++) begin
                compare_word($sformatf("%s C%0d", name, i), exp_c[i],
                             {tx_q[2*i+1], tx_q[2*i+2]});
            end
            compare_byte({name, " tail"}, MARK_END, tx_q[FRAME_BYTES-1]);
        end
        tx_q.delete();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("Test %s passed", name);
        end else begin
            fail_tests++;
            $display("Test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Positive with exponent 120..134 and any mantissa
    function automatic bf16_t random_operand();
        logic [`EXP_W-1:0] e;
        logic [`M_W-1:0] m;
        e = `EXP_W'(120 + ($unsigned($random(seed)) % 15));
        m = `M_W'($random(seed));
        return {1'b0, e, m};
    endfunction

    task automatic idle_after_reset();
        int errs_before;
        errs_before = err_count;
        tx_q.delete();
        @(negedge clk);
        if (tx_valid !== 1'b0) begin
            $display("reset_idle: tx_valid_o is not low after reset");
            err_count++;
        end
        if (busy !== 1'b0) begin
            $display("reset_idle: busy_o is not low after reset");
            err_count++;
        end
        repeat (10) @(posedge clk);
        if (tx_q.size() != 0) begin
            $display("reset_idle: %0d bytes were sent while the link was idle", tx_q.size());
            err_count++;
        end
        tx_q.delete();
        report_test("reset_idle", errs_before);
    endtask

    task automatic identity_frame();
        bf16_t a_m [MAT_WORDS];
        bf16_t b_m [MAT_WORDS];
        bf16_t exp_c [`RESULT_WORDS];
        int errs_before;
        errs_before = err_count;
        a_m = '{16'h3F80, 16'h4000, 16'h4040, 16'h4080};  // 1 2 3 4
        b_m = '{16'h3F80, 16'h0000, 16'h0000, 16'h3F80};  // Identity
        exp_c = a_m;                                      // Exact products make C equal to A
        send_frame(a_m, b_m);
        check_frame("identity", exp_c);
        report_test("identity", errs_before);
    endtask

    task automatic zero_overflow_frame();
        bf16_t a_m [MAT_WORDS];
        bf16_t b_m [MAT_WORDS];
        bf16_t exp_c [`RESULT_WORDS];
        int errs_before;
        errs_before = err_count;
        a_m = '{16'h7F00, 16'h0000, 16'h3F80, 16'h4000};  // 2^127, zero, 1, 2
        b_m = '{16'h7F00, 16'h3F80, 16'h4040, 16'h0000};  // 2^127 squared overflows
        expect_model(a_m, b_m, exp_c);
        send_frame(a_m, b_m);
        check_frame("zero_overflow", exp_c);
        report_test("zero_overflow", errs_before);
    endtask

    task automatic noisy_link_frame();
        bf16_t a_m [MAT_WORDS];
        bf16_t b_m [MAT_WORDS];
        bf16_t exp_c [`RESULT_WORDS];
        byte_t junk [4];
        int errs_before;
        errs_before = err_count;
        a_m = '{16'h4020, 16'h3F00, 16'h3FC0, 16'h4040};  // 2.5 0.5 1.5 3
        b_m = '{16'h3FA0, 16'h4000, 16'h3F40, 16'h3F80};  // 1.25 2 0.75 1
        junk = '{8'hFE, 8'h40, 8'hFF, 8'h3F};             // A start marker among them
        expect_model(a_m, b_m, exp_c);
        tx_q.delete();
        send_byte(8'h12);  // Noise before the start marker
        send_byte(8'hFF);
        send_byte(8'h00);
        send_frame(a_m, b_m);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            if (busy !== 1'b1) begin
                $display("framing: busy_o was low while the multiply was running");
                err_count++;
            end
            send_byte(junk[k]);
        end
        release_link();
        check_frame("framing", exp_c);
        report_test("framing", errs_before);
    endtask

    task automatic random_frames();
        bf16_t a_m [MAT_WORDS];
        bf16_t b_m [MAT_WORDS];
        bf16_t exp_c [`RESULT_WORDS];
        int errs_before;
        errs_before = err_count;
        for (int f = 0; f < 3; f++) begin
            for (int i = 0; i < MAT_WORDS; i++) begin
                a_m[i] = random_operand();
                b_m[i] = random_operand();
            end
            expect_model(a_m, b_m, exp_c);
            send_frame(a_m, b_m);
            check_frame($sformatf("random_%0d", f), exp_c);  // Next frame follows at once
        end
        report_test("random", errs_before);
    endtask

    initial begin
        seed = 32'h37af;
        reset = 1'b0;
        rx_valid = 1'b0;
        rx_byte = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b1;

        idle_after_reset();
        identity_frame();
        zero_overflow_frame();
        noisy_link_frame();
        random_frames();

        $display("Tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
+incdir+testbench
src/float_pkg.sv
src/link_pkg.sv
src/bf16_mul.sv
src/bf16_add.sv
src/processing_element.sv
src/systolic_core.sv
src/frame_controller.sv
src/neural_chip_top.sv
testbench/tb_neural_chip.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the systolic multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_neural_chip -f filelist.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_neural_chip | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
